// File: src/oled_pkg.sv
package oled_pkg;

    // one request as captured from the cpu side
    typedef struct packed {
        logic        pixel;   // 1 = set pixel, 0 = raw byte
        logic [7:0]  x_dc;    // x, or dc in bit 0 and idle cs in bit 1
        logic [7:0]  y_data;  // y, or the raw byte
        logic [15:0] rgb;     // rgb565 colour
    } oled_req_t;

    // one byte on the spi lines with its data/command flag
    typedef struct packed {
        logic       dc;       // 0 = command, 1 = data
        logic [7:0] data;
    } spi_byte_t;

    // serial clock divider, 4 system cycles per half period
    localparam int SPI_DIV_WIDTH = 2;

    // half periods of spi_sck per byte
    localparam int SPI_HALF_PERIODS = 16;
    localparam int SPI_HALF_W = $clog2(SPI_HALF_PERIODS);
    localparam logic [SPI_HALF_W-1:0] SPI_HALF_LAST = SPI_HALF_W'(SPI_HALF_PERIODS - 1);

    // power-up table
    localparam int INIT_LEN = 45;
    localparam int ROM_ADDR_W = 6;
    localparam logic [ROM_ADDR_W-1:0] INIT_END = ROM_ADDR_W'(INIT_LEN);
    localparam logic [7:0] INIT_NOP = 8'hbc;  // returned past the table

    // expanded set-pixel command
    localparam int PIXEL_BYTES = 8;
    localparam int PIX_IDX_W = $clog2(PIXEL_BYTES);
    localparam logic [PIX_IDX_W-1:0] PIX_LAST = PIX_IDX_W'(PIXEL_BYTES - 1);

    // The pixel is drawn as a window that starts at (x, y) and runs to the
    // panel corner, so the colour lands in the first cell of that window.
    localparam logic [7:0] X_END = 8'h5f;  // last column of 96
    localparam logic [7:0] Y_END = 8'h3f;  // last row of 64

    localparam logic [7:0] CMD_SET_COL = 8'h15;
    localparam logic [7:0] CMD_SET_ROW = 8'h75;

endpackage

// File: src/oled_init_rom.sv
`timescale 1ns/1ps

module oled_init_rom (
    input  logic [oled_pkg::ROM_ADDR_W-1:0] rom_addr,
    output logic [7:0]                      rom_data
);

    always_comb begin
        case (rom_addr)
            6'd0:    rom_data = 8'hfd;  // command lock
            6'd1:    rom_data = 8'h12;  // unlock
            6'd2:    rom_data = 8'hae;  // display off
            6'd3:    rom_data = 8'ha0;  // remap and colour depth
            6'd4:    rom_data = 8'h72;  // rgb order, 65k colours
            6'd5:    rom_data = 8'ha1;  // start line
            6'd6:    rom_data = 8'h00;
            6'd7:    rom_data = 8'ha2;  // display offset
            6'd8:    rom_data = 8'h00;
            6'd9:    rom_data = 8'ha4;  // normal display mode
            6'd10:   rom_data = 8'ha8;  // multiplex ratio
            6'd11:   rom_data = 8'h3f;  // 64 rows
            6'd12:   rom_data = 8'had;  // master config
            6'd13:   rom_data = 8'h8e;  // external vcc
            6'd14:   rom_data = 8'hb0;  // power save
            6'd15:   rom_data = 8'h0b;  // disabled
            6'd16:   rom_data = 8'hb1;  // phase length
            6'd17:   rom_data = 8'h31;
            6'd18:   rom_data = 8'hb3;  // clock divide and osc freq
            6'd19:   rom_data = 8'hf0;
            6'd20:   rom_data = 8'h8a;  // precharge a
            6'd21:   rom_data = 8'h64;
            6'd22:   rom_data = 8'h8b;  // precharge b
            6'd23:   rom_data = 8'h78;
            6'd24:   rom_data = 8'h8c;  // precharge c
            6'd25:   rom_data = 8'h64;
            6'd26:   rom_data = 8'hbb;  // precharge level
            6'd27:   rom_data = 8'h3a;
            6'd28:   rom_data = 8'hbe;  // vcomh
            6'd29:   rom_data = 8'h3e;
            6'd30:   rom_data = 8'h87;  // master current
            6'd31:   rom_data = 8'h0f;
            6'd32:   rom_data = 8'h81;  // contrast a
            6'd33:   rom_data = 8'h91;
            6'd34:   rom_data = 8'h82;  // contrast b
            6'd35:   rom_data = 8'h50;
            6'd36:   rom_data = 8'h83;  // contrast c
            6'd37:   rom_data = 8'h7d;
            6'd38:   rom_data = 8'h2e;  // scrolling off
            6'd39:   rom_data = 8'h25;  // clear window, full panel
            6'd40:   rom_data = 8'h00;
            6'd41:   rom_data = 8'h00;
            6'd42:   rom_data = 8'h5f;
            6'd43:   rom_data = 8'h3f;
            6'd44:   rom_data = 8'haf;  // display on
            default: rom_data = oled_pkg::INIT_NOP;
        endcase
    end

endmodule

// File: src/spi_byte_tx.sv
`timescale 1ns/1ps

module spi_byte_tx (
    input  logic                clk,
    input  logic                resetn,
    input  logic                tx_start,
    input  oled_pkg::spi_byte_t tx_byte,
    output logic                tx_done,
    output logic                spi_sck,
    output logic                spi_mosi,
    output logic                spi_dc
);

    logic                              busy;
    logic [oled_pkg::SPI_DIV_WIDTH-1:0] clk_div;
    logic [oled_pkg::SPI_HALF_W-1:0]   half_cnt;  // half periods done in this byte
    logic                              sck_q;
    logic                              dc_q;
    logic [7:0]                        shift_reg;
    logic                              div_wrap;

    assign div_wrap = &clk_div;

    // last falling edge of the byte, the eighth bit is complete
    assign tx_done = busy & div_wrap & (half_cnt == oled_pkg::SPI_HALF_LAST);

    assign spi_sck  = sck_q;
    assign spi_mosi = shift_reg[7];  // msb first
    assign spi_dc   = dc_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy     <= 1'b0;
            clk_div  <= '0;
            half_cnt <= '0;
            sck_q    <= 1'b0;
            dc_q     <= 1'b0;
        end else if (tx_start && !busy) begin
            busy     <= 1'b1;
            clk_div  <= '0;
            half_cnt <= '0;
            sck_q    <= 1'b0;
            dc_q     <= tx_byte.dc;  // held for the whole byte
        end else if (busy) begin
            clk_div <= clk_div + 1'b1;
            if (div_wrap) begin
                sck_q    <= ~sck_q;
                half_cnt <= half_cnt + 1'b1;
                if (tx_done) begin
                    busy <= 1'b0;  // sck is back low here
                end
            end
        end
    end

    // data path, shifts after each falling edge of sck
    always_ff @(posedge clk) begin
        if (tx_start && !busy) begin
            shift_reg <= tx_byte.data;
        end else if (busy && div_wrap && sck_q) begin
            shift_reg <= {shift_reg[6:0], 1'b0};
        end
    end

endmodule

// File: src/oled_sequencer.sv
`timescale 1ns/1ps

module oled_sequencer (
    input  logic                               clk,
    input  logic                               resetn,
    input  logic                               strobe,
    input  oled_pkg::oled_req_t                req,
    input  logic [7:0]                         rom_data,
    output logic [oled_pkg::ROM_ADDR_W-1:0]    rom_addr,
    input  logic                               tx_done,
    output logic                               tx_start,
    output oled_pkg::spi_byte_t                tx_byte,
    output logic                               ready,
    output logic                               valid,
    output logic                               spi_cs
);

    typedef enum logic [2:0] {
        S_INIT_SEND,  // start next rom byte or finish init
        S_INIT_WAIT,  // rom byte in flight
        S_IDLE,
        S_BYTE_WAIT,  // request byte in flight
        S_PIX_BYTE    // start next byte of the request
    } state_t;

    state_t                          state;
    logic [1:0]                      strobe_r;
    logic                            strobe_rise;
    oled_pkg::oled_req_t             req_q;
    logic [oled_pkg::PIX_IDX_W-1:0]  pix_idx;
    oled_pkg::spi_byte_t             pix_byte;
    logic                            last_byte;

    assign strobe_rise = (strobe_r == 2'b01);

    // raw requests are one byte and pixel requests the whole command
    assign last_byte = !req_q.pixel || (pix_idx == oled_pkg::PIX_LAST);

    always_comb begin
        case (pix_idx)
            3'd0:    pix_byte = '{dc: 1'b0, data: oled_pkg::CMD_SET_COL};
            3'd1:    pix_byte = '{dc: 1'b0, data: req_q.x_dc};       // first column
            3'd2:    pix_byte = '{dc: 1'b0, data: oled_pkg::X_END};
            3'd3:    pix_byte = '{dc: 1'b0, data: oled_pkg::CMD_SET_ROW};
            3'd4:    pix_byte = '{dc: 1'b0, data: req_q.y_data};     // first row
            3'd5:    pix_byte = '{dc: 1'b0, data: oled_pkg::Y_END};
            3'd6:    pix_byte = '{dc: 1'b1, data: req_q.rgb[15:8]};  // colour high
            default: pix_byte = '{dc: 1'b1, data: req_q.rgb[7:0]};   // colour low
        endcase
    end

    always_comb begin
        if (state == S_INIT_SEND) begin
            tx_byte = '{dc: 1'b0, data: rom_data};  // init bytes are all commands
        end else if (req_q.pixel) begin
            tx_byte = pix_byte;
        end else begin
            tx_byte = '{dc: req_q.x_dc[0], data: req_q.y_data};
        end
    end

    assign tx_start = ((state == S_INIT_SEND) && (rom_addr != oled_pkg::INIT_END))
                    || (state == S_PIX_BYTE);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state    <= S_INIT_SEND;
            strobe_r <= 2'b11;  // a strobe already high is not an edge
            rom_addr <= '0;
            pix_idx  <= '0;
            ready    <= 1'b0;
            valid    <= 1'b0;
            spi_cs   <= 1'b1;
        end else begin
            strobe_r <= {strobe_r[0], strobe};
            valid    <= 1'b0;

            case (state)
                S_INIT_SEND: begin
                    if (rom_addr == oled_pkg::INIT_END) begin
                        spi_cs <= 1'b1;
                        ready  <= 1'b1;
                        state  <= S_IDLE;
                    end else begin
                        spi_cs <= 1'b0;
                        state  <= S_INIT_WAIT;
                    end
                end

                S_INIT_WAIT: begin
                    if (tx_done) begin
                        rom_addr <= rom_addr + 1'b1;
                        state    <= S_INIT_SEND;
                    end
                end

                S_IDLE: begin
                    spi_cs <= req.x_dc[1];  // cpu frames multi-byte raw transfers
                    if (strobe_rise) begin
                        req_q   <= req;
                        pix_idx <= '0;
                        ready   <= 1'b0;
                        spi_cs  <= 1'b0;
                        state   <= S_PIX_BYTE;
                    end
                end

                S_PIX_BYTE: begin
                    state <= S_BYTE_WAIT;
                end

                S_BYTE_WAIT: begin
                    if (tx_done) begin
                        if (last_byte) begin
                            valid <= 1'b1;
                            ready <= 1'b1;
                            state <= S_IDLE;
                        end else begin
                            pix_idx <= pix_idx + 1'b1;
                            state   <= S_PIX_BYTE;
                        end
                    end
                end

                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

// File: src/oled_ssd1331.sv
`timescale 1ns/1ps

module oled_ssd1331 (
    input  logic        clk,
    input  logic        resetn,

    input  logic        strobe,
    input  logic        setpixel_raw8tx,  // 1 = set pixel, 0 = raw byte
    input  logic [7:0]  x_dc,             // raw mode: dc in bit 0, cs in bit 1
    input  logic [7:0]  y_data,           // raw mode: the byte to send
    input  logic [15:0] rgb,

    output logic        ready,
    output logic        valid,

    output logic        spi_cs,
    output logic        spi_dc,
    output logic        spi_mosi,
    output logic        spi_sck,
    output logic        vccen,
    output logic        pmoden,
    output logic        oled_rst
);

    oled_pkg::oled_req_t                req;
    logic [oled_pkg::ROM_ADDR_W-1:0]    rom_addr;
    logic [7:0]                         rom_data;
    logic                               tx_start;
    logic                               tx_done;
    oled_pkg::spi_byte_t                tx_byte;

    assign req = '{pixel: setpixel_raw8tx, x_dc: x_dc, y_data: y_data, rgb: rgb};

    assign oled_rst = resetn;  // panel reset follows system reset
    assign vccen    = 1'b1;
    assign pmoden   = 1'b1;

    oled_sequencer u_seq (
        .clk      (clk),
        .resetn   (resetn),
        .strobe   (strobe),
        .req      (req),
        .rom_data (rom_data),
        .rom_addr (rom_addr),
        .tx_done  (tx_done),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .ready    (ready),
        .valid    (valid),
        .spi_cs   (spi_cs)
    );

    oled_init_rom u_rom (
        .rom_addr (rom_addr),
        .rom_data (rom_data)
    );

    spi_byte_tx u_tx (
        .clk      (clk),
        .resetn   (resetn),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .tx_done  (tx_done),
        .spi_sck  (spi_sck),
        .spi_mosi (spi_mosi),
        .spi_dc   (spi_dc)
    );

endmodule

// File: bench/oled_checker.sv
`timescale 1ns/1ps

module oled_checker (
    input logic clk,
    input logic resetn,
    input logic spi_cs,
    input logic spi_sck,
    input logic ready,
    input logic valid
);

    int sck_errs = 0;
    int pulse_errs = 0;
    int done_errs = 0;

    // serial clock rests while the panel is deselected
    a_sck_idle: assert property (@(posedge clk) disable iff (!resetn) spi_cs |-> !spi_sck)
        else begin
            sck_errs++;
            $error("spi_sck high while spi_cs is high");
        end

    a_valid_pulse: assert property (@(posedge clk) disable iff (!resetn) valid |=> !valid)
        else begin
            pulse_errs++;
            $error("valid held for more than one cycle");
        end

    // valid closes a transfer, ready was low and the last sck phase was high
    a_valid_done: assert property (@(posedge clk) disable iff (!resetn)
        valid |-> ready && !$past(ready) && $past(spi_sck))
        else begin
            done_errs++;
            $error("valid or ready raised without a preceding transfer");
        end

endmodule

// File: bench/oled_monitor.sv
`timescale 1ns/1ps

module oled_monitor (
    input  logic        clk,
    input  logic        resetn,
    input  logic        setpixel_raw8tx,
    input  logic [7:0]  x_dc,
    input  logic [7:0]  y_data,
    input  logic [15:0] rgb,
    input  logic        ready,
    input  logic        valid,
    input  logic        spi_cs,
    input  logic        spi_dc,
    input  logic        spi_mosi,
    input  logic        spi_sck,
    input  logic        vccen,
    input  logic        pmoden,
    input  logic        oled_rst,
    input  int          test_id,
    input  logic        test_end,
    input  int          exp_reqs,
    output int          tests_passed,
    output int          tests_failed
);

    // ssd1331 power-up bytes as sent in command mode
    localparam logic [7:0] INIT_TABLE [0:44] = '{
        8'hfd, 8'h12, 8'hae, 8'ha0, 8'h72, 8'ha1, 8'h00, 8'ha2, 8'h00, 8'ha4,
        8'ha8, 8'h3f, 8'had, 8'h8e, 8'hb0, 8'h0b, 8'hb1, 8'h31, 8'hb3, 8'hf0,
        8'h8a, 8'h64, 8'h8b, 8'h78, 8'h8c, 8'h64, 8'hbb, 8'h3a, 8'hbe, 8'h3e,
        8'h87, 8'h0f, 8'h81, 8'h91, 8'h82, 8'h50, 8'h83, 8'h7d, 8'h2e, 8'h25,
        8'h00, 8'h00, 8'h5f, 8'h3f, 8'haf
    };

    oled_pkg::oled_req_t req_s;          // request ports at the last clock edge
    oled_pkg::spi_byte_t rx_mem [0:2047];
    oled_pkg::spi_byte_t exp_q [$];
    oled_pkg::spi_byte_t want;
    oled_pkg::spi_byte_t got;
    logic [7:0]          rx_shift = '0;
    int                  rx_bits = 0;
    int                  rx_wr = 0;
    int                  rx_rd = 0;
    logic                ready_q = 1'b0;
    bit                  init_done;
    int                  errs;
    int                  bytes_exp;
    int                  bytes_got;
    int                  accepted;
    int                  valids;
    int                  pending;

    function automatic string test_name(input int id);
        case (id)
            0:       return "power_up";
            1:       return "raw_byte";
            2:       return "set_pixel";
            3:       return "idle_cs";
            4:       return "random";
            default: return "unknown";
        endcase
    endfunction

    // byte idx of the transfer a request should produce
    function automatic oled_pkg::spi_byte_t expected_byte(input oled_pkg::oled_req_t r,
                                                          input int idx);
        oled_pkg::spi_byte_t b;
        b.dc = (idx >= 6) ? 1'b1 : 1'b0;  // colour bytes are data
        case (idx)
            0:       b.data = 8'h15;      // set column
            1:       b.data = r.x_dc;
            2:       b.data = 8'h5f;      // column 95
            3:       b.data = 8'h75;      // set row
            4:       b.data = r.y_data;
            5:       b.data = 8'h3f;      // row 63
            6:       b.data = r.rgb[15:8];
            default: b.data = r.rgb[7:0];
        endcase
        if (!r.pixel) begin
            b.dc   = r.x_dc[0];
            b.data = r.y_data;
        end
        return b;
    endfunction

    // msb first on the rising serial clock
    always @(posedge spi_sck) begin
        if (spi_cs === 1'b0) begin
            rx_shift = {rx_shift[6:0], spi_mosi};
            rx_bits  = rx_bits + 1;
            if (rx_bits == 8) begin
                rx_mem[rx_wr] = {spi_dc, rx_shift};
                rx_wr         = rx_wr + 1;
                rx_bits       = 0;
            end
        end
    end

    always @(posedge clk) begin
        req_s <= {setpixel_raw8tx, x_dc, y_data, rgb};
    end

    always @(negedge clk) begin
        if (!resetn) begin
            exp_q.delete();
            for (int i = 0; i < 45; i++) begin
                want = {1'b0, INIT_TABLE[i]};
                exp_q.push_back(want);
            end
            bytes_exp    = 45;
            bytes_got    = 0;
            errs         = 0;
            accepted     = 0;
            valids       = 0;
            pending      = 0;
            init_done    = 1'b0;
            tests_passed = 0;
            tests_failed = 0;
        end else begin
            while (rx_rd < rx_wr) begin
                got       = rx_mem[rx_rd];
                bytes_got = bytes_got + 1;
                if (exp_q.size() == 0) begin
                    $display("%s: byte %02h (dc %0b) arrived when no byte was expected",
                             test_name(test_id), got.data, got.dc);
                    errs++;
                end else begin
                    want = exp_q.pop_front();
                    if (got !== want) begin
                        $display("FAIL %s byte %0d: expected dc=%0b data=%02h, actual dc=%0b data=%02h",
                                 test_name(test_id), bytes_got - 1, want.dc, want.data,
                                 got.dc, got.data);
                        errs++;
                    end
                end
                rx_rd = rx_rd + 1;
            end
            if (ready_q === 1'b1 && ready === 1'b0) begin  // accepted on the last edge
                accepted++;
                pending++;
                for (int i = 0; i < (req_s.pixel ? 8 : 1); i++) begin
                    want = expected_byte(req_s, i);
                    exp_q.push_back(want);
                    bytes_exp++;
                end
            end
            if (valid === 1'b1) begin
                valids++;
                if (pending == 0) begin
                    $display("%s: valid pulsed with no request in progress", test_name(test_id));
                    errs++;
                end else begin
                    pending--;
                end
            end
            if (ready_q === 1'b0 && ready === 1'b1 && !init_done) begin
                init_done = 1'b1;
                if (spi_cs !== 1'b1) begin
                    $display("FAIL %s chip select after init: expected 1, actual %0b",
                             test_name(test_id), spi_cs);
                    errs++;
                end
            end else if (ready_q === 1'b1 && ready === 1'b1 && spi_cs !== req_s.x_dc[1]) begin
                $display("FAIL %s idle chip select: expected %0b, actual %0b",
                         test_name(test_id), req_s.x_dc[1], spi_cs);
                errs++;
            end
            if (test_end === 1'b1) begin
                if (exp_q.size() != 0) begin
                    $display("%s: %0d expected bytes never arrived",
                             test_name(test_id), exp_q.size());
                    errs++;
                end
                if (accepted != exp_reqs || valids != exp_reqs) begin
                    $display("FAIL %s requests: expected %0d, actual %0d accepted, %0d valid",
                             test_name(test_id), exp_reqs, accepted, valids);
                    errs++;
                end
                if (errs == 0) begin
                    $display("PASS %s: expected %0d bytes, actual %0d bytes",
                             test_name(test_id), bytes_exp, bytes_got);
                    tests_passed++;
                end else begin
                    $display("FAIL %s: expected %0d bytes, actual %0d bytes, %0d errors",
                             test_name(test_id), bytes_exp, bytes_got, errs);
                    tests_failed++;
                end
                exp_q.delete();
                errs      = 0;
                bytes_exp = 0;
                bytes_got = 0;
                accepted  = 0;
                valids    = 0;
            end
        end
        // panel reset follows system reset and the power pins stay on
        if (oled_rst !== resetn) begin
            $display("FAIL %s oled_rst: expected %0b, actual %0b",
                     test_name(test_id), resetn, oled_rst);
            errs++;
        end
        if (vccen !== 1'b1 || pmoden !== 1'b1) begin
            $display("FAIL %s vccen and pmoden: expected 11, actual %0b%0b",
                     test_name(test_id), vccen, pmoden);
            errs++;
        end
        ready_q = ready;
    end

endmodule

// File: bench/tb_oled.sv
`timescale 1ns/1ps

module tb_oled;

    localparam int NUM_TESTS   = 5;
    localparam int RANDOM_REQS = 50;
    // init, two raw, one pixel, one raw, then random requests at worst all pixels
    localparam int TOTAL_BYTES = 45 + 2 + 8 + 1 + 8 * RANDOM_REQS;
    localparam int WATCHDOG_NS = (TOTAL_BYTES * 64 * 2 + 2000) * 100;

    logic        clk = 1'b0;
    logic        resetn;
    logic        strobe;
    logic        setpixel_raw8tx;
    logic [7:0]  x_dc;
    logic [7:0]  y_data;
    logic [15:0] rgb;
    logic        ready;
    logic        valid;
    logic        spi_cs;
    logic        spi_dc;
    logic        spi_mosi;
    logic        spi_sck;
    logic        vccen;
    logic        pmoden;
    logic        oled_rst;
    int          test_id;
    logic        test_end;
    int          exp_reqs;
    int          tests_passed;
    int          tests_failed;
    int          assert_errs;
    logic [31:0] rnd;

    oled_ssd1331 uut (.*);

    oled_monitor mon (.*);

    bind oled_ssd1331 oled_checker chk (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic start_test(input int id);
        @(posedge clk);
        test_id <= id;
    endtask

    task automatic finish_test(input int nreqs);
        @(posedge clk);
        exp_reqs <= nreqs;
        test_end <= 1'b1;
        @(posedge clk);
        test_end <= 1'b0;
    endtask

    // one request, raised only while ready, then wait for valid
    task automatic send_request(input logic pix, input logic [7:0] x, input logic [7:0] y,
                                input logic [15:0] col, input bit extra_edge);
        @(negedge clk);
        while (ready !== 1'b1) @(negedge clk);
        @(posedge clk);
        setpixel_raw8tx <= pix;
        x_dc            <= x;
        y_data          <= y;
        rgb             <= col;
        strobe          <= 1'b1;
        if (extra_edge) begin
            repeat (8) @(posedge clk);
            strobe <= 1'b0;
            repeat (2) @(posedge clk);
            strobe <= 1'b1;  // lands while the byte is in flight
        end
        @(negedge clk);
        while (valid !== 1'b1) @(negedge clk);
        @(posedge clk);
        strobe <= 1'b0;
        @(posedge clk);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the DUT did not finish all tests in %0d ns", WATCHDOG_NS);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        resetn          = 1'b0;
        strobe          = 1'b0;
        setpixel_raw8tx = 1'b0;
        x_dc            = 8'h02;  // idle chip select high
        y_data          = 8'h00;
        rgb             = 16'h0000;
        test_id         = 0;
        test_end        = 1'b0;
        exp_reqs        = 0;
        repeat (5) @(posedge clk);
        resetn <= 1'b1;

        @(negedge clk);
        while (ready !== 1'b1) @(negedge clk);
        finish_test(0);

        start_test(1);
        send_request(1'b0, 8'h03, 8'ha5, 16'h0000, 1'b0);
        send_request(1'b0, 8'h02, 8'h3c, 16'h0000, 1'b0);
        finish_test(2);

        start_test(2);
        send_request(1'b1, 8'h12, 8'h2a, 16'hf81f, 1'b0);
        finish_test(1);

        start_test(3);
        for (int i = 0; i < 6; i++) begin
            @(posedge clk);
            x_dc <= i[0] ? 8'h02 : 8'h00;
            repeat (3) @(posedge clk);
        end
        send_request(1'b0, 8'h01, 8'h5a, 16'h0000, 1'b1);
        finish_test(1);

        start_test(4);
        rnd = 32'd18622;
        for (int i = 0; i < RANDOM_REQS; i++) begin
            rnd = xorshift32(rnd);
            if (rnd[0]) begin
                send_request(1'b1, 8'(rnd[7:1] % 7'd96), {2'b00, rnd[13:8]}, rnd[31:16], 1'b0);
            end else begin
                send_request(1'b0, {6'd0, rnd[2:1]}, rnd[15:8], rnd[31:16], 1'b0);
            end
        end
        finish_test(RANDOM_REQS);

        @(negedge clk);
        assert_errs = uut.chk.sck_errs + uut.chk.pulse_errs + uut.chk.done_errs;
        $display("tests passed: %0d, tests failed: %0d, assertion failures: %0d",
                 tests_passed, tests_failed, assert_errs);
        if (tests_failed == 0 && tests_passed == NUM_TESTS && assert_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: oled_ssd1331.f
src/oled_pkg.sv
src/oled_init_rom.sv
src/spi_byte_tx.sv
src/oled_sequencer.sv
src/oled_ssd1331.sv
bench/oled_checker.sv
bench/oled_monitor.sv
bench/tb_oled.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_oled \
    -f oled_ssd1331.f -o tb_oled_sim || { echo "verilator build failed"; exit 1; }
out=$(./obj_dir/tb_oled_sim +verilator+error+limit+100)
echo "$out"
echo "$out" | grep -qF '*** TEST PASSED ***' && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
